// ==== run_sim.sh ====
#!/bin/sh
# compile the receive path with its testbench, run it, look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f sbit_rx.f --top-module sbit_rx_tb -o sbit_rx_sim &&
./obj_dir/sbit_rx_sim | tee /dev/stderr | grep "Simulation PASSED" > /dev/null &&
echo "run_sim: ok" ||
{ echo "run_sim: failing"; exit 1; }

// ==== sbit_rx.f ====
source/os_pkg.sv
source/phase_ctrl_if.sv
source/sample_deskew.sv
source/phase_voter.sv
source/sbit_rx_top.sv
sim/sbit_rx_tb.sv

// ==== sim/sbit_rx_tb.sv ====
// trigger link receive testbench
`default_nettype none

module sbit_rx_tb import os_pkg::*; ();

  logic                       fastclock;
  logic                       rst;
  sample_word_t               sot_samples;
  sample_word_t [N_SBITS-1:0] sbit_samples;
  logic                       sot_d0, sot_d1;
  lane_bits_t                 sbit_d0, sbit_d1;
  phase_state_t               phase_sel;
  logic                       sel_pos_edge, phase_err, sbit_phase_err;

  // stimulus state with one word of lookahead for the late samples
  logic [31:0] rng;
  int          offset;               // sample n belongs to bit (n + offset) / 4
  logic        sot_neg;              // SoT marker in the second bit
  logic [1:0]  cur_sot, nxt_sot;     // [1] first bit, [0] second
  lane_bits_t  cur_f, cur_s, nxt_f;

  // checking state
  logic [17:0]  exp_q[$];            // {sot pair, first bits, second bits}
  bit           chk_q[$];
  bit           check_en, quiet, lock_phase, exp_pos, saw_err, saw_sbit_err;
  phase_state_t exp_phase;
  string        test_name, timeout_what;
  int           test_errs, tests_run, tests_failed, total_errs, checks;
  event         timeout_ev;

  sbit_rx_top dut0 (
    .fastclock      (fastclock),
    .rst            (rst),
    .sot_samples    (sot_samples),
    .sbit_samples   (sbit_samples),
    .sot_d0         (sot_d0),
    .sot_d1         (sot_d1),
    .sbit_d0        (sbit_d0),
    .sbit_d1        (sbit_d1),
    .phase_sel      (phase_sel),
    .sel_pos_edge   (sel_pos_edge),
    .phase_err      (phase_err),
    .sbit_phase_err (sbit_phase_err)
  );

  always #50 fastclock = ~fastclock;

  // ----------------------------------------------------------------------
  // reference model
  // ----------------------------------------------------------------------

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  // b0 and b1 fill this word and nb0 is the first bit of the next one
  function automatic sample_word_t build_word(input logic b0, input logic b1,
                                              input logic nb0, input int off);
    sample_word_t w;
    int           idx;
    for (int n = 0; n < 8; n++) begin
      idx  = (n + off) / 4;
      w[n] = (idx == 0) ? b0 : ((idx == 1) ? b1 : nb0);
      if (n % 2 == 0) w[n] = ~w[n]; // complementary buffer side
    end
    return w;
  endfunction

  // edges of a repeating SoT marker word
  function automatic logic [3:0] pattern_flags(input logic neg, input int off);
    logic [7:0] t;
    logic [3:0] f;
    t    = build_word(~neg, neg, ~neg, off) ^ 8'h55; // back to true values
    f[0] = (t[0] != t[1]) || (t[4] != t[5]);
    f[1] = (t[1] != t[2]) || (t[5] != t[6]);
    f[2] = (t[2] != t[3]) || (t[6] != t[7]);
    f[3] = (t[3] != t[4]) || (t[7] != t[0]); // wraps onto the same pattern
    return f;
  endfunction

  // move away from the edge next to the selected samples
  function automatic phase_state_t next_phase(input phase_state_t s, input logic [3:0] f);
    case (s)
      PH_00:   return f[0] ? PH_10 : (f[3] ? PH_01 : PH_00);
      PH_01:   return f[1] ? PH_00 : (f[0] ? PH_11 : PH_01);
      PH_11:   return f[2] ? PH_01 : (f[1] ? PH_10 : PH_11);
      default: return f[3] ? PH_11 : (f[2] ? PH_00 : PH_10);
    endcase
  endfunction

  // ----------------------------------------------------------------------
  // checks and stimulus
  // ----------------------------------------------------------------------

  task automatic check_val(input string what, input int expv, input int actv);
    checks++;
    assert (expv == actv) else begin
      $display("error %s: %s expected %0h actual %0h", test_name, what, expv, actv);
      test_errs++;
    end
  endtask

  function automatic int observe(input string which);
    if (which == "phase_sel") return int'(phase_sel);
    else if (which == "sel_pos_edge") return int'(sel_pos_edge);
    else return int'(phase_err);
  endfunction

  // sample outputs, then drive the next word 10 units after the edge
  task automatic step();
    logic [17:0] e;
    bit          c;
    if (quiet) begin
      check_val("phase_err", 0, int'(phase_err));
      check_val("sbit_phase_err", 0, int'(sbit_phase_err));
    end
    if (lock_phase) check_val("phase_sel", int'(exp_phase), int'(phase_sel));
    if (phase_err) saw_err = 1'b1;
    if (sbit_phase_err) saw_sbit_err = 1'b1;
    if (exp_q.size() == 4) begin // word sent four edges ago is on d0/d1
      e = exp_q.pop_front();
      c = chk_q.pop_front();
      if (c) begin
        check_val("sel_pos_edge", int'(exp_pos), int'(sel_pos_edge));
        check_val("sot_d0", int'(exp_pos ? e[17] : e[16]), int'(sot_d0));
        check_val("sot_d1", int'(exp_pos ? e[16] : e[17]), int'(sot_d1));
        check_val("sbit_d0", int'(exp_pos ? e[15:8] : e[7:0]), int'(sbit_d0));
        check_val("sbit_d1", int'(exp_pos ? e[7:0] : e[15:8]), int'(sbit_d1));
      end
    end
    rng     = xorshift(rng);
    cur_sot = nxt_sot;
    nxt_sot = sot_neg ? 2'b01 : 2'b10; // marker bit alone in its half
    cur_f   = nxt_f;
    cur_s   = rng[7:0];
    nxt_f   = rng[15:8];
    sot_samples = build_word(cur_sot[1], cur_sot[0], nxt_sot[1], offset);
    for (int i = 0; i < N_SBITS; i++)
      sbit_samples[i] = build_word(cur_f[i], cur_s[i], nxt_f[i], offset);
    exp_q.push_back({cur_sot, cur_f, cur_s});
    chk_q.push_back(check_en);
    @(posedge fastclock);
    #10;
  endtask

  task automatic run(input int n);
    repeat (n) step();
  endtask

  task automatic wait_until(input string which, input int value, input int limit);
    int n;
    n = 0;
    while (observe(which) != value && n < limit) begin
      step();
      n++;
    end
    if (observe(which) != value) begin
      timeout_what = $sformatf("%s: %s never reached %0d in %0d cycles",
                               test_name, which, value, limit);
      -> timeout_ev;
      forever @(posedge fastclock); // parked until the watchdog ends the run
    end
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    tests_run++;
    total_errs += test_errs;
    if (test_errs == 0) begin
      $display("test %s: ok", test_name);
    end else begin
      $display("test %s: %0d errors", test_name, test_errs);
      tests_failed++;
    end
  endtask

  initial begin
    @(timeout_ev);
    $display("timeout in %s", timeout_what);
    $display("Simulation FAILED");
    $finish;
  end

  // ----------------------------------------------------------------------
  // test sequence
  // ----------------------------------------------------------------------

  initial begin
    fastclock    = 1'b0;
    rst          = 1'b1;
    sot_samples  = '0;
    sbit_samples = '0;
    rng          = 32'he1f37954;
    offset       = 2;        // edges at flag 1 leave pair 0/4 mid bit
    sot_neg      = 1'b0;
    nxt_sot      = 2'b10;
    nxt_f        = '0;
    {check_en, quiet, lock_phase, saw_err, saw_sbit_err} = '0;
    exp_pos      = 1'b1;
    exp_phase    = PH_00;
    {tests_run, tests_failed, total_errs, checks} = '0;
    repeat (3) @(posedge fastclock);
    #10;
    rst = 1'b0;

    begin_test("reset_values");
    check_val("phase_sel", int'(PH_00), int'(phase_sel));
    check_val("sel_pos_edge", 1, int'(sel_pos_edge));
    check_val("sot_d0/d1", 0, int'({sot_d0, sot_d1}));
    check_val("sbit_d0/d1", 0, int'({sbit_d0, sbit_d1}));
    check_val("phase_err", 0, int'(phase_err));
    check_val("sbit_phase_err", 0, int'(sbit_phase_err));
    end_test();

    begin_test("centered_data");
    lock_phase = 1'b1;
    run(8);                  // reset junk drains out of the pipeline
    {quiet, check_en} = 2'b11;
    run(300);
    end_test();

    begin_test("edge_in_samples");
    {quiet, check_en, lock_phase} = '0;
    offset    = 0;           // edges now next to samples 0 and 4
    exp_phase = next_phase(PH_00, pattern_flags(1'b0, 0));
    wait_until("phase_err", 1, 20);
    wait_until("phase_sel", int'(exp_phase), 2000);
    run(8);
    {quiet, check_en, lock_phase} = 3'b111;
    run(200);
    end_test();

    begin_test("hysteresis");
    quiet   = 1'b0;
    saw_err = 1'b0;
    repeat (4) begin         // each burst is far below the vote limit
      offset = 2;
      run(100);
      offset = 0;
      run(80);
    end
    check_val("phase_err seen", 1, int'(saw_err));
    quiet = 1'b1;
    run(20);
    end_test();

    begin_test("polarity");
    check_en = 1'b0;
    sot_neg  = 1'b1;
    wait_until("sel_pos_edge", 0, 20);
    exp_pos = 1'b0;          // marker and s-bits leave on d0 swapped
    run(6);
    check_en = 1'b1;
    run(200);
    end_test();

    begin_test("sbit_follow");
    {quiet, check_en, lock_phase, saw_sbit_err} = '0;
    sot_neg   = 1'b0;
    offset    = 2;           // SoT and s-bits shift together
    exp_phase = next_phase(PH_01, pattern_flags(1'b0, 2));
    wait_until("phase_sel", int'(exp_phase), 2000);
    wait_until("sel_pos_edge", 1, 20);
    exp_pos = 1'b1;          // marker back on the first bit
    check_val("sbit_phase_err seen", 1, int'(saw_sbit_err));
    run(8);
    {quiet, check_en, lock_phase} = 3'b111;
    run(300);
    end_test();

    $display("tests %0d  failed %0d  checks %0d  errors %0d",
             tests_run, tests_failed, checks, total_errs);
    if (tests_failed == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== source/os_pkg.sv ====
// oversampler shared definitions
`default_nettype none

package os_pkg;

  // ----------------------------------------------------------------------
  // sample and lane widths
  // ----------------------------------------------------------------------

  // one clock of raw oversamples, index n taken at n*45 degrees
  // samples 0..3 cover the first bit period, 4..7 the second
  typedef logic [7:0] sample_word_t;

  // transition flags, bit k compares true samples k and k+1 in both halves
  // bit 3 wraps: 3 vs 4, and sample 7 of the previous word vs sample 0
  typedef logic [3:0] edge_flags_t;

  // selected sample pair, [1] first bit period, [0] second
  typedef logic [1:0] bit_pair_t;

  localparam int unsigned N_SBITS = 8; // s-bit data lanes beside the SoT lane

  typedef logic [N_SBITS-1:0] lane_bits_t; // one bit per s-bit lane

  // even samples come from the complementary buffer output
  localparam sample_word_t INVERT_MASK = 8'h55;

  // ----------------------------------------------------------------------
  // phase voter
  // ----------------------------------------------------------------------

  // XAPP881 sample phase, encoding follows the original gray-ish numbering
  typedef enum logic [1:0] {
    PH_00 = 2'd0, // samples 0 and 4
    PH_01 = 2'd1, // samples 1 and 5
    PH_10 = 2'd2, // samples 3 and 7
    PH_11 = 2'd3  // samples 2 and 6
  } phase_state_t;

  // error votes needed before the phase may move
  localparam int unsigned ERR_LIMIT = 255;

  // clean cycles that mark the link stable and drop accumulated votes
  localparam int unsigned STABLE_LIMIT = 63;

  typedef logic [7:0] err_count_t;    // holds up to ERR_LIMIT
  typedef logic [5:0] stable_count_t; // holds up to STABLE_LIMIT

endpackage

`default_nettype wire

// ==== source/phase_ctrl_if.sv ====
// lane to voter phase control bundle
`default_nettype none

interface phase_ctrl_if import os_pkg::*; ();

  // ----------------------------------------------------------------------
  // voter side
  // ----------------------------------------------------------------------
  phase_state_t phase_sel;    // which sample pair the lane forwards
  logic         sel_pos_edge; // high: first sample of the pair goes to d0

  // ----------------------------------------------------------------------
  // lane side
  // ----------------------------------------------------------------------
  edge_flags_t  edge_flags;   // registered transition flags
  logic         phase_err;    // edge next to the selected samples

  // a sampling lane follows the voter
  modport lane (
    input  phase_sel,
    input  sel_pos_edge,
    output edge_flags,
    output phase_err
  );

  // the voter watches the SoT lane
  modport voter (
    output phase_sel,
    output sel_pos_edge,
    input  edge_flags,
    input  phase_err
  );

endinterface

`default_nettype wire

// ==== source/phase_voter.sv ====
// SoT phase voter
`default_nettype none

module phase_voter import os_pkg::*; (
  input  logic         fastclock,
  input  logic         rst,
  input  logic         first_bit,   // SoT pair before ordering
  input  logic         second_bit,
  phase_ctrl_if.voter  ctrl
);

  // ----------------------------------------------------------------------
  // hysteresis counters
  // ----------------------------------------------------------------------

  phase_state_t  phase_q;       // current sample phase
  phase_state_t  phase_last;    // phase one cycle ago
  phase_state_t  phase_next;
  err_count_t    err_count;     // error votes
  stable_count_t stable_count;  // clean cycles in a row
  logic          vote_to_shift;
  logic          link_stable;
  logic          phase_moved;

  assign vote_to_shift = (err_count == err_count_t'(ERR_LIMIT));
  assign link_stable   = (stable_count == stable_count_t'(STABLE_LIMIT));
  assign phase_moved   = (phase_last != phase_q);

  always_ff @(posedge fastclock) begin
    if (rst) begin
      stable_count <= '0;
      err_count    <= '0;
      phase_last   <= PH_00;
    end else begin
      // any error restarts the clean run, saturate once stable
      if (ctrl.phase_err)
        stable_count <= '0;
      else if (!link_stable)
        stable_count <= stable_count + stable_count_t'(1);

      phase_last <= phase_q;

      // a long clean run forgives old hiccups
      // votes are spent on a move and dropped after it
      if (link_stable || phase_moved || vote_to_shift)
        err_count <= '0;
      else if (ctrl.phase_err)
        err_count <= err_count + err_count_t'(1);
    end
  end

  // ----------------------------------------------------------------------
  // XAPP881 phase FSM
  // ----------------------------------------------------------------------

  // step away from whichever side the edge is on
  always_comb begin
    phase_next = phase_q;
    if (vote_to_shift) begin
      case (phase_q)
        PH_00: begin
          if      (ctrl.edge_flags[0]) phase_next = PH_10;
          else if (ctrl.edge_flags[3]) phase_next = PH_01;
        end
        PH_01: begin
          if      (ctrl.edge_flags[1]) phase_next = PH_00;
          else if (ctrl.edge_flags[0]) phase_next = PH_11;
        end
        PH_11: begin
          if      (ctrl.edge_flags[2]) phase_next = PH_01;
          else if (ctrl.edge_flags[1]) phase_next = PH_10;
        end
        PH_10: begin
          if      (ctrl.edge_flags[3]) phase_next = PH_11;
          else if (ctrl.edge_flags[2]) phase_next = PH_00;
        end
      endcase
    end
  end

  always_ff @(posedge fastclock) begin
    if (rst)
      phase_q <= PH_00;
    else
      phase_q <= phase_next; // at most one step per saturation
  end

  // ----------------------------------------------------------------------
  // SoT polarity
  // ----------------------------------------------------------------------

  logic data_on_neg; // marker sits in the second sample of the pair

  // hold the last decision while the SoT pair is quiet
  always_ff @(posedge fastclock) begin
    if (rst)
      data_on_neg <= 1'b0;
    else if (first_bit)
      data_on_neg <= 1'b0;
    else if (second_bit)
      data_on_neg <= 1'b1;
  end

  assign ctrl.phase_sel    = phase_q;
  assign ctrl.sel_pos_edge = ~data_on_neg;

endmodule

`default_nettype wire

// ==== source/sample_deskew.sv ====
// four-phase sample deskew lane
`default_nettype none

module sample_deskew import os_pkg::*; (
  input  logic         fastclock,
  input  logic         rst,
  input  sample_word_t samples,     // deserialized word, even bits inverted
  phase_ctrl_if.lane   ctrl,
  output logic         d0,          // first recovered bit
  output logic         d1,          // second recovered bit
  output logic         pair_first,  // selected pair before ordering
  output logic         pair_second
);

  // ----------------------------------------------------------------------
  // capture, uninvert and edge detection
  // ----------------------------------------------------------------------

  sample_word_t raw_q;    // stage 1: word as captured
  sample_word_t unv_q;    // stage 2: true sample values
  edge_flags_t  flags_q;  // stage 2: transitions seen in raw_q
  logic         prev_s7;  // last true sample of the word before raw_q

  // unv_q is one word behind raw_q while the flags are formed
  assign prev_s7 = unv_q[7];

  always_ff @(posedge fastclock) begin
    if (rst) begin
      raw_q   <= '0;
      unv_q   <= '0;
      flags_q <= '0;
    end else begin
      raw_q <= samples;
      unv_q <= raw_q ^ INVERT_MASK; // flip even samples back

      // neighbours have opposite polarity on the wire
      // so an equal raw pair means the true values differ
      flags_q[0] <= (raw_q[0] == raw_q[1]) || (raw_q[4] == raw_q[5]);
      flags_q[1] <= (raw_q[1] == raw_q[2]) || (raw_q[5] == raw_q[6]);
      flags_q[2] <= (raw_q[2] == raw_q[3]) || (raw_q[6] == raw_q[7]);
      // prev_s7 is already true, raw_q[0] is still inverted
      flags_q[3] <= (raw_q[3] == raw_q[4]) || (prev_s7 == raw_q[0]);
    end
  end

  // ----------------------------------------------------------------------
  // phase select
  // ----------------------------------------------------------------------

  bit_pair_t pair_sel;  // pair picked by the current phase
  logic      err_sel;   // an edge borders the picked samples
  bit_pair_t pair_q;    // stage 3
  logic      err_q;

  always_comb begin
    pair_sel = {unv_q[0], unv_q[4]};
    err_sel  = flags_q[0] | flags_q[3];
    case (ctrl.phase_sel)
      PH_00: begin // 0 and 180 degrees of each bit
        pair_sel = {unv_q[0], unv_q[4]};
        err_sel  = flags_q[0] | flags_q[3];
      end
      PH_01: begin
        pair_sel = {unv_q[1], unv_q[5]};
        err_sel  = flags_q[1] | flags_q[0];
      end
      PH_11: begin
        pair_sel = {unv_q[2], unv_q[6]};
        err_sel  = flags_q[2] | flags_q[1];
      end
      PH_10: begin // latest samples of each period
        pair_sel = {unv_q[3], unv_q[7]};
        err_sel  = flags_q[3] | flags_q[2];
      end
    endcase
  end

  always_ff @(posedge fastclock) begin
    if (rst) begin
      pair_q <= '0;
      err_q  <= 1'b0;
    end else begin
      pair_q <= pair_sel;
      err_q  <= err_sel;
    end
  end

  // ----------------------------------------------------------------------
  // output ordering
  // ----------------------------------------------------------------------

  always_ff @(posedge fastclock) begin
    if (rst) begin
      d0 <= 1'b0;
      d1 <= 1'b0;
    end else begin
      d0 <= pair_q[ ctrl.sel_pos_edge]; // first sample when marker is on pos
      d1 <= pair_q[~ctrl.sel_pos_edge];
    end
  end

  assign ctrl.edge_flags = flags_q;
  assign ctrl.phase_err  = err_q;
  assign pair_first      = pair_q[1];
  assign pair_second     = pair_q[0];

endmodule

`default_nettype wire

// ==== source/sbit_rx_top.sv ====
// trigger link receive top
`default_nettype none

module sbit_rx_top import os_pkg::*; (
  input  logic                       fastclock,
  input  logic                       rst,
  input  sample_word_t               sot_samples,
  input  sample_word_t [N_SBITS-1:0] sbit_samples,
  output logic                       sot_d0,
  output logic                       sot_d1,
  output lane_bits_t                 sbit_d0,
  output lane_bits_t                 sbit_d1,
  output phase_state_t               phase_sel,
  output logic                       sel_pos_edge,
  output logic                       phase_err,      // SoT lane
  output logic                       sbit_phase_err  // any s-bit lane
);

  // ----------------------------------------------------------------------
  // SoT lane and voter
  // ----------------------------------------------------------------------

  phase_ctrl_if sot_ctrl ();

  logic sot_first;  // unordered SoT pair for the polarity tracker
  logic sot_second;

  sample_deskew sot_lane (
    .fastclock   (fastclock),
    .rst         (rst),
    .samples     (sot_samples),
    .ctrl        (sot_ctrl),
    .d0          (sot_d0),
    .d1          (sot_d1),
    .pair_first  (sot_first),
    .pair_second (sot_second)
  );

  phase_voter voter (
    .fastclock  (fastclock),
    .rst        (rst),
    .first_bit  (sot_first),
    .second_bit (sot_second),
    .ctrl       (sot_ctrl)
  );

  // ----------------------------------------------------------------------
  // s-bit lanes, phase matched to SoT
  // ----------------------------------------------------------------------

  lane_bits_t lane_err; // per lane phase error

  genvar i;
  generate
    for (i = 0; i < N_SBITS; i++) begin : g_sbit
      phase_ctrl_if lane_ctrl ();

      // lanes follow the SoT decision, nobody votes on their flags
      assign lane_ctrl.phase_sel    = sot_ctrl.phase_sel;
      assign lane_ctrl.sel_pos_edge = sot_ctrl.sel_pos_edge;

      sample_deskew sbit_lane (
        .fastclock   (fastclock),
        .rst         (rst),
        .samples     (sbit_samples[i]),
        .ctrl        (lane_ctrl),
        .d0          (sbit_d0[i]),
        .d1          (sbit_d1[i]),
        .pair_first  (),
        .pair_second ()
      );

      assign lane_err[i] = lane_ctrl.phase_err;
    end
  endgenerate

  assign phase_sel      = sot_ctrl.phase_sel;
  assign sel_pos_edge   = sot_ctrl.sel_pos_edge;
  assign phase_err      = sot_ctrl.phase_err;
  assign sbit_phase_err = |lane_err; // flags a lane out of step with SoT

endmodule

`default_nettype wire
